//--- logic/frame_split_pkg.sv
package frame_split_pkg;

    // stream widths
    localparam int BYTE_W  = 8;
    localparam int INDEX_W = 5;
    localparam int FIELD_W = 24;

    // dds parameter widths
    localparam int TYPE_W   = 3;
    localparam int FRQ_W    = 24;
    localparam int AMP_W    = 12;
    localparam int OFFSET_W = 13;
    localparam int PHASE_W  = 12;
    localparam int DUTY_W   = 10;

    // logic analyzer widths
    localparam int FRQ_SEL_W    = 4;
    localparam int TRIG_MODEL_W = 3;
    localparam int TRIG_CH_W    = 8;

    // byte positions inside a frame
    localparam logic [INDEX_W-1:0] KIND_INDEX       = 5'd2;
    localparam logic [INDEX_W-1:0] LOGIC_CH_INDEX   = 5'd6;
    localparam logic [INDEX_W-1:0] LOGIC_MODE_INDEX = 5'd7;
    localparam logic [INDEX_W-1:0] LOGIC_CTRL_INDEX = 5'd8;
    localparam logic [INDEX_W-1:0] DDS1_BASE        = 5'd6;
    localparam logic [INDEX_W-1:0] DDS2_BASE        = 5'd18;
    localparam logic [INDEX_W-1:0] DDS_SPAN         = 5'd12;

    typedef enum logic [BYTE_W-1:0] {
        KIND_LOGIC = 8'd0,
        KIND_DDS   = 8'd1
    } frame_kind_e;

    typedef enum logic [3:0] {
        F_NONE,
        F_LOGIC_CH,
        F_LOGIC_MODE,
        F_LOGIC_CTRL,
        F_CTRL,
        F_FRQ,
        F_AMP,
        F_OFFSET,
        F_PHASE,
        F_DUTY
    } field_id_e;

endpackage

//--- logic/frame_byte_if.sv
`timescale 1ns/1ps

interface frame_byte_if;
    import frame_split_pkg::*;

    logic [BYTE_W-1:0]  data;
    logic [INDEX_W-1:0] index;
    frame_kind_e        kind;
    logic               valid;

    // one byte per valid cycle, no ready
    modport producer (
        output data, index, kind, valid
    );

    modport consumer (
        input data, index, kind, valid
    );
endinterface

//--- logic/field_if.sv
`timescale 1ns/1ps

interface field_if;
    import frame_split_pkg::*;

    field_id_e          id;
    logic               chan;
    logic [FIELD_W-1:0] value;
    logic               valid;

    // valid is a single-cycle strobe per finished field
    modport producer (
        output id, chan, value, valid
    );

    modport consumer (
        input id, chan, value, valid
    );
endinterface

//--- logic/frame_indexer.sv
`timescale 1ns/1ps

module frame_indexer (
    input  logic                               i_clk,
    input  logic                               i_rst,
    input  logic [frame_split_pkg::BYTE_W-1:0] i_udma_data,
    input  logic                               i_udma_vld,
    frame_byte_if.producer                     bus
);
    import frame_split_pkg::*;

    logic [BYTE_W-1:0]  r_data;
    logic               r_vld;
    logic [INDEX_W-1:0] r_cnt;

    // input stage
    always_ff @(posedge i_clk)
    begin
        r_data   <= i_udma_data;
        bus.data <= r_data;
    end

    // index of the byte now held in r_data, saturates at all ones
    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            r_vld <= 1'b0;
            r_cnt <= '0;
        end
        else
        begin
            r_vld <= i_udma_vld;
            if (!r_vld)
                r_cnt <= '0;
            else if (r_cnt != '1)
                r_cnt <= r_cnt + 1'b1;
        end
    end

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            bus.index <= '0;
            bus.valid <= 1'b0;
            bus.kind  <= KIND_LOGIC;
        end
        else
        begin
            bus.index <= r_cnt;
            bus.valid <= r_vld;
            // kind byte goes out already tagged with itself
            if (r_vld && r_cnt == KIND_INDEX)
                bus.kind <= frame_kind_e'(r_data);
        end
    end

endmodule

//--- logic/field_assembler.sv
`timescale 1ns/1ps

module field_assembler (
    input  logic           i_clk,
    input  logic           i_rst,
    frame_byte_if.consumer byte_bus,
    field_if.producer      field_bus
);
    import frame_split_pkg::*;

    field_id_e          w_id;
    logic               w_first;
    logic               w_last;
    logic               w_chan;
    logic               w_in_span;
    logic [INDEX_W-1:0] w_off;
    logic [FIELD_W-1:0] r_acc;

    // the two dds spans sit back to back
    assign w_in_span = byte_bus.index >= DDS1_BASE && byte_bus.index < DDS2_BASE + DDS_SPAN;
    assign w_chan    = byte_bus.index >= DDS2_BASE;
    assign w_off     = byte_bus.index - (w_chan ? DDS2_BASE : DDS1_BASE);

    //////////////////////////////
    // byte to field mapping
    always_comb
    begin
        w_id    = F_NONE;
        w_first = 1'b1;
        w_last  = 1'b1;
        if (byte_bus.kind == KIND_LOGIC)
        begin
            if (byte_bus.index == LOGIC_CH_INDEX)
                w_id = F_LOGIC_CH;
            else if (byte_bus.index == LOGIC_MODE_INDEX)
                w_id = F_LOGIC_MODE;
            else if (byte_bus.index == LOGIC_CTRL_INDEX)
                w_id = F_LOGIC_CTRL;
        end
        else if (byte_bus.kind == KIND_DDS && w_in_span)
        begin
            case (w_off)
                0:
                    w_id = F_CTRL;
                1, 2, 3:
                begin
                    w_id    = F_FRQ;
                    w_first = (w_off == 1);
                    w_last  = (w_off == 3);
                end
                default:
                begin
                    // two-byte fields, high byte on even offset
                    w_first = !w_off[0];
                    w_last  = w_off[0];
                    case (w_off)
                        4, 5:    w_id = F_AMP;
                        6, 7:    w_id = F_OFFSET;
                        8, 9:    w_id = F_PHASE;
                        10, 11:  w_id = F_DUTY;
                        default: w_id = F_NONE;
                    endcase
                end
            endcase
        end
    end

    //////////////////////////////
    // msb first shift in
    always_ff @(posedge i_clk)
    begin
        if (byte_bus.valid && w_id != F_NONE)
        begin
            if (w_first)
                r_acc <= FIELD_W'(byte_bus.data);
            else
                r_acc <= {r_acc[FIELD_W-BYTE_W-1:0], byte_bus.data};
        end
        field_bus.id   <= w_id;
        field_bus.chan <= w_chan;
    end

    assign field_bus.value = r_acc;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
            field_bus.valid <= 1'b0;
        else
            field_bus.valid <= byte_bus.valid && w_last && w_id != F_NONE;
    end

endmodule

//--- logic/dds_param_bank.sv
`timescale 1ns/1ps

module dds_param_bank #(
    parameter logic BANK_INDEX = 1'b0
) (
    input  logic                                 i_clk,
    input  logic                                 i_rst,
    field_if.consumer                            field_bus,
    output logic                                 o_run,
    output logic                                 o_run_vld,
    output logic [frame_split_pkg::TYPE_W-1:0]   o_type,
    output logic                                 o_type_vld,
    output logic [frame_split_pkg::FRQ_W-1:0]    o_frq,
    output logic                                 o_frq_vld,
    output logic [frame_split_pkg::AMP_W-1:0]    o_amp,
    output logic                                 o_amp_vld,
    output logic [frame_split_pkg::OFFSET_W-1:0] o_offset,
    output logic                                 o_offset_vld,
    output logic [frame_split_pkg::PHASE_W-1:0]  o_phase,
    output logic                                 o_phase_vld,
    output logic [frame_split_pkg::DUTY_W-1:0]   o_duty,
    output logic                                 o_duty_vld
);
    import frame_split_pkg::*;

    logic w_hit;

    assign w_hit = field_bus.valid && field_bus.chan == BANK_INDEX;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            o_run        <= 1'b0;
            o_run_vld    <= 1'b0;
            o_type       <= '0;
            o_type_vld   <= 1'b0;
            o_frq        <= '0;
            o_frq_vld    <= 1'b0;
            o_amp        <= '0;
            o_amp_vld    <= 1'b0;
            o_offset     <= '0;
            o_offset_vld <= 1'b0;
            o_phase      <= '0;
            o_phase_vld  <= 1'b0;
            o_duty       <= '0;
            o_duty_vld   <= 1'b0;
        end
        else
        begin
            o_run_vld    <= 1'b0;
            o_type_vld   <= 1'b0;
            o_frq_vld    <= 1'b0;
            o_amp_vld    <= 1'b0;
            o_offset_vld <= 1'b0;
            o_phase_vld  <= 1'b0;
            o_duty_vld   <= 1'b0;
            if (w_hit)
            begin
                case (field_bus.id)
                    F_CTRL:
                    begin
                        // bit 3 run, low bits waveform
                        o_run      <= field_bus.value[3];
                        o_run_vld  <= 1'b1;
                        o_type     <= field_bus.value[TYPE_W-1:0];
                        o_type_vld <= 1'b1;
                    end
                    F_FRQ:
                    begin
                        o_frq     <= field_bus.value[FRQ_W-1:0];
                        o_frq_vld <= 1'b1;
                    end
                    F_AMP:
                    begin
                        o_amp     <= field_bus.value[AMP_W-1:0];
                        o_amp_vld <= 1'b1;
                    end
                    F_OFFSET:
                    begin
                        o_offset     <= field_bus.value[OFFSET_W-1:0];
                        o_offset_vld <= 1'b1;
                    end
                    F_PHASE:
                    begin
                        o_phase     <= field_bus.value[PHASE_W-1:0];
                        o_phase_vld <= 1'b1;
                    end
                    F_DUTY:
                    begin
                        o_duty     <= field_bus.value[DUTY_W-1:0];
                        o_duty_vld <= 1'b1;
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- logic/logic_cfg_regs.sv
`timescale 1ns/1ps

module logic_cfg_regs (
    input  logic                                     i_clk,
    input  logic                                     i_rst,
    field_if.consumer                                field_bus,
    output logic [frame_split_pkg::TRIG_CH_W-1:0]    o_trig_channel,
    output logic [frame_split_pkg::TRIG_MODEL_W-1:0] o_trig_model,
    output logic [frame_split_pkg::FRQ_SEL_W-1:0]    o_frq_sel,
    output logic                                     o_send_model,
    output logic                                     o_pulse
);
    import frame_split_pkg::*;

    always_ff @(posedge i_clk or posedge i_rst)
    begin
        if (i_rst)
        begin
            o_trig_channel <= '0;
            o_trig_model   <= '0;
            o_frq_sel      <= '0;
            o_send_model   <= 1'b0;
            o_pulse        <= 1'b0;
        end
        else
        begin
            o_pulse <= 1'b0;
            if (field_bus.valid)
            begin
                case (field_bus.id)
                    F_LOGIC_CH:
                        o_trig_channel <= field_bus.value[TRIG_CH_W-1:0];
                    F_LOGIC_MODE:
                    begin
                        // mode in bits 6:4, rate select below it
                        o_trig_model <= field_bus.value[FRQ_SEL_W +: TRIG_MODEL_W];
                        o_frq_sel    <= field_bus.value[FRQ_SEL_W-1:0];
                    end
                    F_LOGIC_CTRL:
                    begin
                        o_send_model <= field_bus.value[0];
                        // start request
                        o_pulse      <= field_bus.value[1];
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

//--- logic/uart_frame_splitter.sv
`timescale 1ns/1ps

module uart_frame_splitter (
    input  logic                                     i_clk,
    input  logic                                     i_rst,
    input  logic [frame_split_pkg::BYTE_W-1:0]       i_udma_data,
    input  logic                                     i_udma_vld,

    output logic                                     o_logic_pulse,
    output logic [frame_split_pkg::FRQ_SEL_W-1:0]    o_logic_frq_sel,
    output logic [frame_split_pkg::TRIG_MODEL_W-1:0] o_logic_trig_model,
    output logic [frame_split_pkg::TRIG_CH_W-1:0]    o_logic_trig_channel,
    output logic                                     o_logic_send_model,

    output logic                                     o_dds1_run,
    output logic                                     o_dds1_run_vld,
    output logic [frame_split_pkg::TYPE_W-1:0]       o_dds1_type,
    output logic                                     o_dds1_type_vld,
    output logic [frame_split_pkg::FRQ_W-1:0]        o_dds1_frq,
    output logic                                     o_dds1_frq_vld,
    output logic [frame_split_pkg::AMP_W-1:0]        o_dds1_amp,
    output logic                                     o_dds1_amp_vld,
    output logic [frame_split_pkg::OFFSET_W-1:0]     o_dds1_offset,
    output logic                                     o_dds1_offset_vld,
    output logic [frame_split_pkg::PHASE_W-1:0]      o_dds1_phase,
    output logic                                     o_dds1_phase_vld,
    output logic [frame_split_pkg::DUTY_W-1:0]       o_dds1_duty,
    output logic                                     o_dds1_duty_vld,

    output logic                                     o_dds2_run,
    output logic                                     o_dds2_run_vld,
    output logic [frame_split_pkg::TYPE_W-1:0]       o_dds2_type,
    output logic                                     o_dds2_type_vld,
    output logic [frame_split_pkg::FRQ_W-1:0]        o_dds2_frq,
    output logic                                     o_dds2_frq_vld,
    output logic [frame_split_pkg::AMP_W-1:0]        o_dds2_amp,
    output logic                                     o_dds2_amp_vld,
    output logic [frame_split_pkg::OFFSET_W-1:0]     o_dds2_offset,
    output logic                                     o_dds2_offset_vld,
    output logic [frame_split_pkg::PHASE_W-1:0]      o_dds2_phase,
    output logic                                     o_dds2_phase_vld,
    output logic [frame_split_pkg::DUTY_W-1:0]       o_dds2_duty,
    output logic                                     o_dds2_duty_vld
);

    frame_byte_if byte_bus ();
    field_if      field_bus ();

    //////////////////////////////
    // byte stream to fields
    frame_indexer u_indexer (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_udma_data (i_udma_data),
        .i_udma_vld  (i_udma_vld),
        .bus         (byte_bus)
    );

    field_assembler u_assembler (
        .i_clk     (i_clk),
        .i_rst     (i_rst),
        .byte_bus  (byte_bus),
        .field_bus (field_bus)
    );

    //////////////////////////////
    // register banks
    logic_cfg_regs u_logic_cfg (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .field_bus      (field_bus),
        .o_trig_channel (o_logic_trig_channel),
        .o_trig_model   (o_logic_trig_model),
        .o_frq_sel      (o_logic_frq_sel),
        .o_send_model   (o_logic_send_model),
        .o_pulse        (o_logic_pulse)
    );

    dds_param_bank #(
        .BANK_INDEX (1'b0)
    ) u_dds1 (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .field_bus    (field_bus),
        .o_run        (o_dds1_run),
        .o_run_vld    (o_dds1_run_vld),
        .o_type       (o_dds1_type),
        .o_type_vld   (o_dds1_type_vld),
        .o_frq        (o_dds1_frq),
        .o_frq_vld    (o_dds1_frq_vld),
        .o_amp        (o_dds1_amp),
        .o_amp_vld    (o_dds1_amp_vld),
        .o_offset     (o_dds1_offset),
        .o_offset_vld (o_dds1_offset_vld),
        .o_phase      (o_dds1_phase),
        .o_phase_vld  (o_dds1_phase_vld),
        .o_duty       (o_dds1_duty),
        .o_duty_vld   (o_dds1_duty_vld)
    );

    dds_param_bank #(
        .BANK_INDEX (1'b1)
    ) u_dds2 (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .field_bus    (field_bus),
        .o_run        (o_dds2_run),
        .o_run_vld    (o_dds2_run_vld),
        .o_type       (o_dds2_type),
        .o_type_vld   (o_dds2_type_vld),
        .o_frq        (o_dds2_frq),
        .o_frq_vld    (o_dds2_frq_vld),
        .o_amp        (o_dds2_amp),
        .o_amp_vld    (o_dds2_amp_vld),
        .o_offset     (o_dds2_offset),
        .o_offset_vld (o_dds2_offset_vld),
        .o_phase      (o_dds2_phase),
        .o_phase_vld  (o_dds2_phase_vld),
        .o_duty       (o_dds2_duty),
        .o_duty_vld   (o_dds2_duty_vld)
    );

endmodule

//--- verification/frame_model.svh
// expected register state per frame
logic [7:0]  exp_trig_ch;
logic [2:0]  exp_trig_model;
logic [3:0]  exp_frq_sel;
logic        exp_send;
int          exp_pulse_cnt;
logic        exp_run [2];
logic [2:0]  exp_type [2];
logic [23:0] exp_frq [2];
logic [11:0] exp_amp [2];
logic [12:0] exp_offset [2];
logic [11:0] exp_phase [2];
logic [9:0]  exp_duty [2];
// strobes ordered run, type, frq, amp, offset, phase, duty
int          exp_vld_cnt [2][7];

task automatic check_value(input string what, input logic [31:0] got,
                           input logic [31:0] expected);
    if (got !== expected)
    begin
        $display("error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
        $display("Simulation finished: FAIL");
        $fatal(1, "value mismatch");
    end
endtask

task automatic model_reset();
    exp_trig_ch    = '0;
    exp_trig_model = '0;
    exp_frq_sel    = '0;
    exp_send       = 1'b0;
    exp_pulse_cnt  = 0;
    for (int ch = 0; ch < 2; ch++)
    begin
        exp_run[ch]    = 1'b0;
        exp_type[ch]   = '0;
        exp_frq[ch]    = '0;
        exp_amp[ch]    = '0;
        exp_offset[ch] = '0;
        exp_phase[ch]  = '0;
        exp_duty[ch]   = '0;
        for (int f = 0; f < 7; f++)
            exp_vld_cnt[ch][f] = 0;
    end
endtask

task automatic model_frame(input int len);
    int          base;
    logic [15:0] word;
    exp_pulse_cnt = 0;
    for (int ch = 0; ch < 2; ch++)
        for (int f = 0; f < 7; f++)
            exp_vld_cnt[ch][f] = 0;
    if (frame_bytes[2] == 8'd0)
    begin
        if (len > 6)
            exp_trig_ch = frame_bytes[6];
        if (len > 7)
        begin
            exp_trig_model = frame_bytes[7][6:4];
            exp_frq_sel    = frame_bytes[7][3:0];
        end
        if (len > 8)
        begin
            exp_send      = frame_bytes[8][0];
            exp_pulse_cnt = frame_bytes[8][1];
        end
    end
    else if (frame_bytes[2] == 8'd1)
    begin
        for (int ch = 0; ch < 2; ch++)
        begin
            base = 6 + 12 * ch;
            if (len > base)
            begin
                exp_run[ch]        = frame_bytes[base][3];
                exp_type[ch]       = frame_bytes[base][2:0];
                exp_vld_cnt[ch][0] = 1;
                exp_vld_cnt[ch][1] = 1;
            end
            // frequency msb first
            if (len > base + 3)
            begin
                exp_frq[ch] = {frame_bytes[base + 1], frame_bytes[base + 2],
                               frame_bytes[base + 3]};
                exp_vld_cnt[ch][2] = 1;
            end
            // two-byte fields from offset 4 on
            for (int f = 3; f < 7; f++)
            begin
                if (len > base + 2 * f - 1)
                begin
                    word = {frame_bytes[base + 2 * f - 2], frame_bytes[base + 2 * f - 1]};
                    exp_vld_cnt[ch][f] = 1;
                    case (f)
                        3:       exp_amp[ch]    = word[11:0];
                        4:       exp_offset[ch] = word[12:0];
                        5:       exp_phase[ch]  = word[11:0];
                        default: exp_duty[ch]   = word[9:0];
                    endcase
                end
            end
        end
    end
endtask

//--- verification/tb_frame_splitter.sv
`timescale 1ns/1ps

module tb_frame_splitter;

    localparam int NUM_FRAMES  = 48;
    localparam int CYCLE_LIMIT = 40 * NUM_FRAMES + 100;

    logic        i_clk;
    logic        i_rst;
    logic [7:0]  i_udma_data;
    logic        i_udma_vld;

    logic        o_logic_pulse;
    logic [3:0]  o_logic_frq_sel;
    logic [2:0]  o_logic_trig_model;
    logic [7:0]  o_logic_trig_channel;
    logic        o_logic_send_model;
    logic        o_dds1_run;
    logic        o_dds2_run;
    logic [2:0]  o_dds1_type;
    logic [2:0]  o_dds2_type;
    logic [23:0] o_dds1_frq;
    logic [23:0] o_dds2_frq;
    logic [11:0] o_dds1_amp;
    logic [11:0] o_dds2_amp;
    logic [12:0] o_dds1_offset;
    logic [12:0] o_dds2_offset;
    logic [11:0] o_dds1_phase;
    logic [11:0] o_dds2_phase;
    logic [9:0]  o_dds1_duty;
    logic [9:0]  o_dds2_duty;
    logic        o_dds1_run_vld;
    logic        o_dds1_type_vld;
    logic        o_dds1_frq_vld;
    logic        o_dds1_amp_vld;
    logic        o_dds1_offset_vld;
    logic        o_dds1_phase_vld;
    logic        o_dds1_duty_vld;
    logic        o_dds2_run_vld;
    logic        o_dds2_type_vld;
    logic        o_dds2_frq_vld;
    logic        o_dds2_amp_vld;
    logic        o_dds2_offset_vld;
    logic        o_dds2_phase_vld;
    logic        o_dds2_duty_vld;

    logic [1:0][6:0] dds_vld;
    int          got_vld_cnt [2][7];
    int          got_pulse_cnt;
    int          cycle_cnt = 0;
    logic [31:0] lcg_state;
    logic [7:0]  frame_bytes [30];

    `include "frame_model.svh"

    uart_frame_splitter uut (.*);

    assign dds_vld[0] = {o_dds1_duty_vld, o_dds1_phase_vld, o_dds1_offset_vld,
                         o_dds1_amp_vld, o_dds1_frq_vld, o_dds1_type_vld, o_dds1_run_vld};
    assign dds_vld[1] = {o_dds2_duty_vld, o_dds2_phase_vld, o_dds2_offset_vld,
                         o_dds2_amp_vld, o_dds2_frq_vld, o_dds2_type_vld, o_dds2_run_vld};

    initial
        i_clk = 1'b0;
    always #5 i_clk = ~i_clk;

    //////////////////////////////
    // strobe counting and timeout
    always @(negedge i_clk)
    begin
        for (int ch = 0; ch < 2; ch++)
            for (int f = 0; f < 7; f++)
                if (dds_vld[ch][f])
                    got_vld_cnt[ch][f]++;
        if (o_logic_pulse)
            got_pulse_cnt++;
    end

    always @(posedge i_clk)
    begin
        cycle_cnt++;
        if (cycle_cnt > CYCLE_LIMIT)
        begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [7:0] rand_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];
    endfunction

    task automatic clear_counts();
        got_pulse_cnt = 0;
        for (int ch = 0; ch < 2; ch++)
            for (int f = 0; f < 7; f++)
                got_vld_cnt[ch][f] = 0;
    endtask

    task automatic build_frame(input int sel, output int len);
        for (int i = 0; i < 30; i++)
            frame_bytes[i] = rand_byte();
        case (sel)
            0:
            begin
                frame_bytes[2] = 8'd0;
                len = 9 + rand_byte() % 4;
            end
            1:
            begin
                frame_bytes[2] = 8'd1;
                len = 30;
            end
            2:
            begin
                // unknown kind
                if (frame_bytes[2] < 8'd2)
                    frame_bytes[2] = frame_bytes[2] + 8'd2;
                len = 9 + rand_byte() % 22;
            end
            default:
            begin
                // dds frame that stops after byte 12
                frame_bytes[2] = 8'd1;
                len = 13;
            end
        endcase
    endtask

    // starts and returns on a falling edge
    task automatic send_frame(input int len);
        for (int i = 0; i < len; i++)
        begin
            i_udma_data = frame_bytes[i];
            i_udma_vld  = 1'b1;
            @(negedge i_clk);
        end
        i_udma_vld  = 1'b0;
        i_udma_data = 8'h00;
        repeat (5) @(negedge i_clk);
    endtask

    task automatic check_outputs();
        check_value("trig channel", o_logic_trig_channel, exp_trig_ch);
        check_value("trig mode", o_logic_trig_model, exp_trig_model);
        check_value("sample rate select", o_logic_frq_sel, exp_frq_sel);
        check_value("send mode", o_logic_send_model, exp_send);
        check_value("start pulse count", got_pulse_cnt, exp_pulse_cnt);
        check_value("dds1 run", o_dds1_run, exp_run[0]);
        check_value("dds1 type", o_dds1_type, exp_type[0]);
        check_value("dds1 frq", o_dds1_frq, exp_frq[0]);
        check_value("dds1 amp", o_dds1_amp, exp_amp[0]);
        check_value("dds1 offset", o_dds1_offset, exp_offset[0]);
        check_value("dds1 phase", o_dds1_phase, exp_phase[0]);
        check_value("dds1 duty", o_dds1_duty, exp_duty[0]);
        check_value("dds2 run", o_dds2_run, exp_run[1]);
        check_value("dds2 type", o_dds2_type, exp_type[1]);
        check_value("dds2 frq", o_dds2_frq, exp_frq[1]);
        check_value("dds2 amp", o_dds2_amp, exp_amp[1]);
        check_value("dds2 offset", o_dds2_offset, exp_offset[1]);
        check_value("dds2 phase", o_dds2_phase, exp_phase[1]);
        check_value("dds2 duty", o_dds2_duty, exp_duty[1]);
        for (int ch = 0; ch < 2; ch++)
            for (int f = 0; f < 7; f++)
                check_value($sformatf("dds%0d strobe %0d count", ch + 1, f),
                            got_vld_cnt[ch][f], exp_vld_cnt[ch][f]);
    endtask

    //////////////////////////////
    // main sequence
    initial
    begin
        int len;
        i_rst       = 1'b1;
        i_udma_data = 8'h00;
        i_udma_vld  = 1'b0;
        lcg_state   = 32'd45;
        clear_counts();
        model_reset();
        repeat (3) @(posedge i_clk);
        @(negedge i_clk);
        i_rst = 1'b0;
        @(negedge i_clk);
        check_outputs();

        // logic, dds, unknown kind and short dds frames in turn
        for (int n = 0; n < NUM_FRAMES; n++)
        begin
            build_frame(n % 4, len);
            model_frame(len);
            clear_counts();
            send_frame(len);
            check_outputs();
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- sources.f
+incdir+verification
logic/frame_split_pkg.sv
logic/frame_byte_if.sv
logic/field_if.sv
logic/frame_indexer.sv
logic/field_assembler.sv
logic/dds_param_bank.sv
logic/logic_cfg_regs.sv
logic/uart_frame_splitter.sv
verification/tb_frame_splitter.sv
